/* design/hacd_wr_pkg.sv */
// HACD write path package
// Bus widths, vector types, fixed AXI write encodings and FSM state types

package hacd_wr_pkg;

    ////////////////////
    // Bus widths
    ////////////////////
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 64;
    localparam int STRB_W     = DATA_W / 8;
    localparam int ID_W       = 4;
    localparam int CNT_W      = 16;

    // W-data FIFO depth must be a power of two
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    ////////////////////
    // AXI encodings
    ////////////////////
    // 8 bytes per beat
    localparam logic [2:0] AXI_SIZE         = 3'b011;
    localparam logic [1:0] AXI_BURST_INCR   = 2'b01;
    // Unprivileged, non-secure, data access
    localparam logic [2:0] AXI_PROT_DEFAULT = 3'b010;
    localparam logic [1:0] RESP_OKAY        = 2'b00;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [CNT_W-1:0]  cnt_t;

    // Client bridge sequence
    typedef enum logic [1:0] {
        BR_IDLE,
        BR_ADDR,
        BR_DATA,
        BR_ACK
    } bridge_state_t;

    // AW hold machine in the master
    typedef enum logic {
        HOLD_IDLE,
        HOLD_FILL
    } hold_state_t;

endpackage

/* design/client_req_bridge.sv */
// Client request bridge
// Converts the four-phase req/ack client handshake into one AW transfer
// followed by one W transfer on valid/ready, then closes with ack
`timescale 1ns/10ps

module client_req_bridge (
    input  logic               clk,
    input  logic               rst,
    // Client side
    input  logic               req,
    input  hacd_wr_pkg::addr_t wr_addr,
    input  hacd_wr_pkg::data_t wr_data,
    output logic               ack,
    // AW toward the master
    output logic               s_awvalid,
    output hacd_wr_pkg::addr_t s_awaddr,
    input  logic               s_awready,
    // W toward the master
    output logic               s_wvalid,
    output hacd_wr_pkg::data_t s_wdata,
    input  logic               s_wready
);
    import hacd_wr_pkg::*;

    bridge_state_t state;
    addr_t         addr_q;
    data_t         data_q;

    ////////////////////
    // Sequence FSM
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= BR_IDLE;
        end else begin
            case (state)
                BR_IDLE: begin
                    if (req) begin
                        state <= BR_ADDR;
                    end
                end
                BR_ADDR: begin
                    // Move on to the data word once the address is accepted
                    if (s_awvalid && s_awready) begin
                        state <= BR_DATA;
                    end
                end
                BR_DATA: begin
                    if (s_wvalid && s_wready) begin
                        state <= BR_ACK;
                    end
                end
                BR_ACK: begin
                    // Hold ack until the client drops req
                    if (!req) begin
                        state <= BR_IDLE;
                    end
                end
                default: begin
                    state <= BR_IDLE;
                end
            endcase
        end
    end

    // Capture client payload as the request is taken
    always_ff @(posedge clk) begin
        if (state == BR_IDLE && req) begin
            addr_q <= wr_addr;
            data_q <= wr_data;
        end
    end

    assign s_awvalid = (state == BR_ADDR);
    assign s_awaddr  = addr_q;
    assign s_wvalid  = (state == BR_DATA);
    assign s_wdata   = data_q;
    assign ack       = (state == BR_ACK);

endmodule

/* design/axi_write_master.sv */
// AXI4 write master
// Stages write data in a small FIFO with a registered read and output stage,
// and holds each AW until its single W beat is stored, then issues
// single-beat INCR bursts on the AXI write channels
`timescale 1ns/10ps

module axi_write_master (
    input  logic                             clk,
    input  logic                             rst,
    // Upstream AW
    input  logic                             s_awvalid,
    input  hacd_wr_pkg::addr_t               s_awaddr,
    output logic                             s_awready,
    // Upstream W
    input  logic                             s_wvalid,
    input  hacd_wr_pkg::data_t               s_wdata,
    output logic                             s_wready,
    // AXI AW channel
    output logic [hacd_wr_pkg::ID_W-1:0]     awid,
    output hacd_wr_pkg::addr_t               awaddr,
    output logic [7:0]                       awlen,
    output logic [2:0]                       awsize,
    output logic [1:0]                       awburst,
    output logic [2:0]                       awprot,
    output logic                             awvalid,
    input  logic                             awready,
    // AXI W channel
    output hacd_wr_pkg::data_t               wdata,
    output logic [hacd_wr_pkg::STRB_W-1:0]   wstrb,
    output logic                             wlast,
    output logic                             wvalid,
    input  logic                             wready
);
    import hacd_wr_pkg::*;

    // FIFO storage and pointers with an extra MSB to tell full from empty
    data_t            mem [0:FIFO_DEPTH-1];
    logic [FIFO_AW:0] wr_ptr;
    logic [FIFO_AW:0] rd_ptr;
    logic             full;
    logic             empty;
    logic             wr_en;
    logic             rd_en;

    // Read stage between memory and output register
    data_t            rd_data;
    logic             rd_valid;
    logic             store_out;

    // AW hold machine
    hold_state_t      hold_state;
    logic             hold;

    ////////////////////
    // Fixed burst fields
    ////////////////////
    // In-order only, single beat with all bytes enabled
    assign awid    = '0;
    assign awlen   = 8'd0;
    assign awsize  = AXI_SIZE;
    assign awburst = AXI_BURST_INCR;
    assign awprot  = AXI_PROT_DEFAULT;
    assign wstrb   = '1;
    assign wlast   = 1'b1;

    ////////////////////
    // AW hold machine
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            hold_state <= HOLD_IDLE;
            hold       <= 1'b1;
            s_awready  <= 1'b0;
            awvalid    <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                awvalid <= 1'b0;
            end
            case (hold_state)
                HOLD_IDLE: begin
                    // No new address while the previous one is still on the bus
                    s_awready <= !awvalid;
                    if (s_awvalid && s_awready) begin
                        s_awready  <= 1'b0;
                        hold       <= 1'b0;
                        hold_state <= HOLD_FILL;
                    end
                end
                HOLD_FILL: begin
                    // One beat per burst so AW goes out once it is in the FIFO
                    if (wr_en) begin
                        awvalid    <= 1'b1;
                        hold       <= 1'b1;
                        hold_state <= HOLD_IDLE;
                    end
                end
                default: begin
                    hold_state <= HOLD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (s_awvalid && s_awready) begin
            awaddr <= s_awaddr;
        end
    end

    ////////////////////
    // FIFO write side
    ////////////////////
    assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                   (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign s_wready = !full && !hold;
    assign wr_en    = s_wvalid && s_wready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= s_wdata;
        end
    end

    ////////////////////
    // FIFO read side
    ////////////////////
    // Output register takes a new word when the bus accepts or it is empty
    assign store_out = wready || !wvalid;
    assign rd_en     = (store_out || !rd_valid) && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (store_out || !rd_valid) begin
                rd_valid <= !empty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_ptr[FIFO_AW-1:0]];
        end
    end

    // W channel output register
    always_ff @(posedge clk) begin
        if (rst) begin
            wvalid <= 1'b0;
        end else if (store_out) begin
            wvalid <= rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (store_out) begin
            wdata <= rd_data;
        end
    end

endmodule

/* design/bresp_tracker.sv */
// Write response tracker
// Counts writes in flight, completed writes and error responses from the
// B channel, with bready held high
`timescale 1ns/10ps

module bresp_tracker (
    input  logic              clk,
    input  logic              rst,
    input  logic              awvalid,
    input  logic              awready,
    input  logic              bvalid,
    input  logic [1:0]        bresp,
    output logic              bready,
    output hacd_wr_pkg::cnt_t outstanding,
    output hacd_wr_pkg::cnt_t completed,
    output hacd_wr_pkg::cnt_t err_count
);
    import hacd_wr_pkg::*;

    logic aw_fire;
    logic b_fire;

    // Always ready for a response
    assign bready  = 1'b1;
    assign aw_fire = awvalid && awready;
    assign b_fire  = bvalid && bready;

    ////////////////////
    // Counters
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= '0;
        end else begin
            case ({aw_fire, b_fire})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                // Issue and retire together cancel out
                default: outstanding <= outstanding;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            completed <= '0;
        end else if (b_fire) begin
            completed <= completed + 1'b1;
        end
    end

    // SLVERR and DECERR both land here
    always_ff @(posedge clk) begin
        if (rst) begin
            err_count <= '0;
        end else if (b_fire && (bresp != RESP_OKAY)) begin
            err_count <= err_count + 1'b1;
        end
    end

endmodule

/* design/axi_wr_top.sv */
// AXI write path top level
// Client req/ack bridge, write master with data FIFO and B response tracker
`timescale 1ns/10ps

module axi_wr_top (
    input  logic                             clk,
    input  logic                             rst,
    // Client
    input  logic                             req,
    input  hacd_wr_pkg::addr_t               wr_addr,
    input  hacd_wr_pkg::data_t               wr_data,
    output logic                             ack,
    // AXI AW channel
    output logic [hacd_wr_pkg::ID_W-1:0]     awid,
    output hacd_wr_pkg::addr_t               awaddr,
    output logic [7:0]                       awlen,
    output logic [2:0]                       awsize,
    output logic [1:0]                       awburst,
    output logic [2:0]                       awprot,
    output logic                             awvalid,
    input  logic                             awready,
    // AXI W channel
    output hacd_wr_pkg::data_t               wdata,
    output logic [hacd_wr_pkg::STRB_W-1:0]   wstrb,
    output logic                             wlast,
    output logic                             wvalid,
    input  logic                             wready,
    // AXI B channel without an ID since writes stay in order
    input  logic [1:0]                       bresp,
    input  logic                             bvalid,
    output logic                             bready,
    // Response counts
    output hacd_wr_pkg::cnt_t                outstanding,
    output hacd_wr_pkg::cnt_t                completed,
    output hacd_wr_pkg::cnt_t                err_count
);
    import hacd_wr_pkg::*;

    // Bridge to master
    logic  s_awvalid;
    addr_t s_awaddr;
    logic  s_awready;
    logic  s_wvalid;
    data_t s_wdata;
    logic  s_wready;

    client_req_bridge i_bridge (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .ack       (ack),
        .s_awvalid (s_awvalid),
        .s_awaddr  (s_awaddr),
        .s_awready (s_awready),
        .s_wvalid  (s_wvalid),
        .s_wdata   (s_wdata),
        .s_wready  (s_wready)
    );

    axi_write_master i_master (
        .clk       (clk),
        .rst       (rst),
        .s_awvalid (s_awvalid),
        .s_awaddr  (s_awaddr),
        .s_awready (s_awready),
        .s_wvalid  (s_wvalid),
        .s_wdata   (s_wdata),
        .s_wready  (s_wready),
        .awid      (awid),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awsize    (awsize),
        .awburst   (awburst),
        .awprot    (awprot),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .wready    (wready)
    );

    bresp_tracker i_tracker (
        .clk         (clk),
        .rst         (rst),
        .awvalid     (awvalid),
        .awready     (awready),
        .bvalid      (bvalid),
        .bresp       (bresp),
        .bready      (bready),
        .outstanding (outstanding),
        .completed   (completed),
        .err_count   (err_count)
    );

endmodule

/* dv/axi_wr_assert.sv */
// AXI write path protocol assertions
// Bound to the top level, covers AW/W valid stability, ack after reset
// and wlast on every single-beat W transfer
`timescale 1ns/10ps

module axi_wr_assert (
    input logic               clk,
    input logic               rst,
    input logic               ack,
    input logic               awvalid,
    input logic               awready,
    input hacd_wr_pkg::addr_t awaddr,
    input logic               wvalid,
    input logic               wready,
    input hacd_wr_pkg::data_t wdata,
    input logic               wlast
);

    // AW held with a stable address until accepted
    a_aw_stable: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("AW valid or address changed before awready");

    a_w_stable: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("W valid or data changed before wready");

    a_ack_reset: assert property (@(posedge clk) rst |=> !ack)
        else $error("ack high right after reset");

    // Single-beat bursts only
    a_wlast: assert property (@(posedge clk) disable iff (rst) wvalid |-> wlast)
        else $error("wvalid without wlast");

endmodule

bind axi_wr_top axi_wr_assert i_assert (
    .clk     (clk),
    .rst     (rst),
    .ack     (ack),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wlast   (wlast)
);

/* dv/tb_axi_mem_slave.sv */
// AXI write slave model
// Random AW/W ready stalls plus a triggered long W stall, associative
// memory, in-order B responses with SLVERR at or above an error base
`timescale 1ns/10ps

module tb_axi_mem_slave (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         stall_start,
    input  hacd_wr_pkg::addr_t           err_base,
    input  logic [hacd_wr_pkg::ID_W-1:0] awid,
    input  hacd_wr_pkg::addr_t           awaddr,
    input  logic [7:0]                   awlen,
    input  logic [2:0]                   awsize,
    input  logic [1:0]                   awburst,
    input  logic [2:0]                   awprot,
    input  logic                         awvalid,
    output logic                         awready,
    input  hacd_wr_pkg::data_t           wdata,
    input  logic [hacd_wr_pkg::STRB_W-1:0] wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready
);
    import hacd_wr_pkg::*;

    localparam int         STALL_LEN   = 80;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    integer      seed = 32'h697b;
    logic [31:0] rnd;
    int          stall_cnt;
    logic        awready_q = 1'b0;
    logic        wready_q  = 1'b0;
    logic        bvalid_q  = 1'b0;
    logic [1:0]  bresp_q   = 2'b00;
    addr_t       pop_addr;
    data_t       pop_data;

    // Pending AW and W halves that pair up in order
    addr_t aw_q [$];
    data_t w_q [$];

    // Logs and memory read by the testbench
    addr_t                 awaddr_log [$];
    logic [ID_W-1:0]       awid_log [$];
    logic [7:0]            awlen_log [$];
    logic [2:0]            awsize_log [$];
    logic [1:0]            awburst_log [$];
    logic [2:0]            awprot_log [$];
    logic [STRB_W-1:0]     wstrb_log [$];
    data_t                 mem [addr_t];

    assign awready = awready_q;
    assign wready  = wready_q;
    assign bvalid  = bvalid_q;
    assign bresp   = bresp_q;

    always @(posedge clk) begin
        if (rst) begin
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            bvalid_q  <= 1'b0;
            bresp_q   <= RESP_OKAY;
            stall_cnt <= 0;
        end else begin
            rnd = $random(seed);
            if (awvalid && awready_q) begin
                aw_q.push_back(awaddr);
                awaddr_log.push_back(awaddr);
                awid_log.push_back(awid);
                awlen_log.push_back(awlen);
                awsize_log.push_back(awsize);
                awburst_log.push_back(awburst);
                awprot_log.push_back(awprot);
            end
            if (wvalid && wready_q) begin
                w_q.push_back(wdata);
                wstrb_log.push_back(wstrb);
            end
            if (stall_start) begin
                stall_cnt <= STALL_LEN;
            end else if (stall_cnt > 0) begin
                stall_cnt <= stall_cnt - 1;
            end
            // Ready about three cycles in four
            awready_q <= rnd[0] | rnd[1];
            wready_q  <= (stall_cnt == 0) && !stall_start && (rnd[2] | rnd[3]);
            if (bvalid_q && bready) begin
                bvalid_q <= 1'b0;
            end
            if ((!bvalid_q || bready) && aw_q.size() > 0 && w_q.size() > 0) begin
                pop_addr      = aw_q.pop_front();
                pop_data      = w_q.pop_front();
                mem[pop_addr] = pop_data;
                bvalid_q     <= 1'b1;
                bresp_q      <= (pop_addr >= err_base) ? RESP_SLVERR : RESP_OKAY;
            end
        end
    end

endmodule

/* dv/tb_axi_wr_top.sv */
// Testbench for the AXI write path
// Drives a table of client writes through req/ack, models the AXI slave
// beside the DUT and checks memory contents, AW order, burst fields and counts
`timescale 1ns/10ps

module tb_axi_wr_top;
    import hacd_wr_pkg::*;

    localparam int    NUM_ROWS     = 14;
    // First row of the group that runs under a long W stall
    localparam int    STALL_ROW    = 6;
    localparam int    ACK_TIMEOUT  = 1000;
    localparam int    DONE_TIMEOUT = 2000;
    // Responses at or above this address come back as SLVERR
    localparam addr_t ERR_BASE     = 32'h8000_0000;

    logic              clk;
    logic              rst;
    logic              req;
    addr_t             wr_addr;
    data_t             wr_data;
    logic              ack;
    logic [ID_W-1:0]   awid;
    addr_t             awaddr;
    logic [7:0]        awlen;
    logic [2:0]        awsize;
    logic [1:0]        awburst;
    logic [2:0]        awprot;
    logic              awvalid;
    logic              awready;
    data_t             wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wlast;
    logic              wvalid;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              bready;
    cnt_t              outstanding;
    cnt_t              completed;
    cnt_t              err_count;
    logic              stall_start;
    logic              ack_prev = 1'b0;
    int                value_errors = 0;
    int                proto_errors = 0;

    // Stimulus table
    string row_name [NUM_ROWS];
    addr_t row_addr [NUM_ROWS];
    data_t row_data [NUM_ROWS];
    bit    row_err  [NUM_ROWS];

    axi_wr_top i_dut (.*);

    tb_axi_mem_slave i_slave (
        .clk         (clk),
        .rst         (rst),
        .stall_start (stall_start),
        .err_base    (ERR_BASE),
        .awid        (awid),
        .awaddr      (awaddr),
        .awlen       (awlen),
        .awsize      (awsize),
        .awburst     (awburst),
        .awprot      (awprot),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // Table and checks
    ////////////////////
    task automatic set_row(input int idx, input string name, input addr_t addr,
                           input data_t data, input bit err);
        row_name[idx] = name;
        row_addr[idx] = addr;
        row_data[idx] = data;
        row_err[idx]  = err;
    endtask

    task automatic load_table;
        set_row(0,  "base_a",    32'h0000_1000, 64'h0123_4567_89ab_cdef, 1'b0);
        set_row(1,  "base_b",    32'h0000_1008, 64'hfedc_ba98_7654_3210, 1'b0);
        set_row(2,  "rewrite_a", 32'h0000_1000, 64'hdead_beef_0000_0001, 1'b0);
        set_row(3,  "err_low",   32'h8000_0000, 64'h5555_aaaa_5555_aaaa, 1'b1);
        set_row(4,  "below_err", 32'h7fff_fff8, 64'h0f0f_0f0f_f0f0_f0f0, 1'b0);
        set_row(5,  "err_high",  32'h8000_0040, 64'hcafe_f00d_1234_5678, 1'b1);
        // Long wready stall from here on so the FIFO fills and ack stretches
        set_row(6,  "stall_0",   32'h0000_4000, 64'h4000_0000_0000_0a00, 1'b0);
        set_row(7,  "stall_1",   32'h0000_4008, 64'h4000_0000_0000_0a01, 1'b0);
        set_row(8,  "stall_2",   32'h0000_4010, 64'h4000_0000_0000_0a02, 1'b0);
        set_row(9,  "stall_3",   32'h0000_4018, 64'h4000_0000_0000_0a03, 1'b0);
        set_row(10, "stall_4",   32'h0000_4020, 64'h4000_0000_0000_0a04, 1'b0);
        set_row(11, "stall_5",   32'h8000_0080, 64'h4000_0000_0000_0a05, 1'b1);
        set_row(12, "stall_6",   32'h0000_4030, 64'h4000_0000_0000_0a06, 1'b0);
        set_row(13, "stall_7",   32'h0000_4000, 64'h4000_0000_0000_0a07, 1'b0);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act == exp) else begin
            value_errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // One four-phase transfer for a table row
    task automatic send_row(input int idx);
        int cnt;
        @(posedge clk);
        req     <= 1'b1;
        wr_addr <= row_addr[idx];
        wr_data <= row_data[idx];
        if (idx == STALL_ROW) begin
            stall_start <= 1'b1;
        end
        @(posedge clk);
        stall_start <= 1'b0;
        cnt = 0;
        @(negedge clk);
        while (!ack && cnt < ACK_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!ack) begin
            proto_errors++;
            $display("Error: no ack for row %s within %0d cycles", row_name[idx], ACK_TIMEOUT);
        end
        @(posedge clk);
        req <= 1'b0;
        cnt = 0;
        @(negedge clk);
        while (ack && cnt < ACK_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (ack) begin
            proto_errors++;
            $display("Error: ack stayed high after req dropped for row %s", row_name[idx]);
        end
    endtask

    task automatic wait_counts;
        int cnt;
        cnt = 0;
        while (completed != cnt_t'(NUM_ROWS) && cnt < DONE_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (completed != cnt_t'(NUM_ROWS)) begin
            proto_errors++;
            $display("Error: only %0d of %0d writes completed in time", completed, NUM_ROWS);
        end
        cnt = 0;
        while (outstanding != '0 && cnt < DONE_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (outstanding != '0) begin
            proto_errors++;
            $display("Error: %0d writes still outstanding after the timeout", outstanding);
        end
    endtask

    task automatic check_counts;
        int i;
        int exp_err;
        exp_err = 0;
        for (i = 0; i < NUM_ROWS; i++) begin
            exp_err += int'(row_err[i]);
        end
        check_value("completed", 64'(NUM_ROWS), 64'(completed));
        check_value("err_count", 64'(exp_err), 64'(err_count));
        check_value("outstanding", 64'h0, 64'(outstanding));
    endtask

    // AW order and burst fields with one AW and one W beat per row
    task automatic check_slave_log;
        int i;
        check_value("aw_count", 64'(NUM_ROWS), 64'(i_slave.awaddr_log.size()));
        check_value("w_count", 64'(NUM_ROWS), 64'(i_slave.wstrb_log.size()));
        for (i = 0; i < NUM_ROWS && i < i_slave.awaddr_log.size(); i++) begin
            check_value({row_name[i], " awaddr"}, 64'(row_addr[i]),
                        64'(i_slave.awaddr_log[i]));
            check_value({row_name[i], " awid"}, 64'h0, 64'(i_slave.awid_log[i]));
            check_value({row_name[i], " awlen"}, 64'h0, 64'(i_slave.awlen_log[i]));
            check_value({row_name[i], " awburst"}, 64'h1, 64'(i_slave.awburst_log[i]));
            // 8-byte beats as non-secure data accesses
            check_value({row_name[i], " awsize"}, 64'h3, 64'(i_slave.awsize_log[i]));
            check_value({row_name[i], " awprot"}, 64'h2, 64'(i_slave.awprot_log[i]));
        end
        for (i = 0; i < NUM_ROWS && i < i_slave.wstrb_log.size(); i++) begin
            check_value({row_name[i], " wstrb"}, 64'({STRB_W{1'b1}}),
                        64'(i_slave.wstrb_log[i]));
        end
    endtask

    // Last table write per address must be what the slave holds
    task automatic check_memory;
        int    i;
        data_t exp_mem [addr_t];
        string exp_name [addr_t];
        for (i = 0; i < NUM_ROWS; i++) begin
            exp_mem[row_addr[i]]  = row_data[i];
            exp_name[row_addr[i]] = row_name[i];
        end
        foreach (exp_mem[a]) begin
            assert (i_slave.mem.exists(a)) else begin
                value_errors++;
                $display("Error: slave memory has no beat at %h for row %s", a, exp_name[a]);
            end
            if (i_slave.mem.exists(a)) begin
                check_value({exp_name[a], " memory"}, exp_mem[a], i_slave.mem[a]);
            end
        end
    endtask

    // ack may only rise while req is held
    always @(negedge clk) begin
        if (!rst) begin
            assert (!(ack && !ack_prev) || req) else begin
                proto_errors++;
                $display("Error: ack rose while req was low");
            end
        end
        ack_prev = ack;
    end

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        rst         = 1'b1;
        req         = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        stall_start = 1'b0;
        load_table();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            send_row(i);
        end
        wait_counts();
        check_counts();
        check_slave_log();
        check_memory();
        $display("Errors: %0d value mismatches, %0d protocol or timeout failures",
                 value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
design/hacd_wr_pkg.sv
design/client_req_bridge.sv
design/axi_write_master.sv
design/bresp_tracker.sv
design/axi_wr_top.sv
dv/axi_wr_assert.sv
dv/tb_axi_mem_slave.sv
dv/tb_axi_wr_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the AXI write path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f all.f \
    --top-module tb_axi_wr_top -Mdir obj_dir -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "Testbench reported failure"
    exit 1
fi
if [ "$status" -ne 0 ] || grep -q "%Error" sim.log; then
    echo "Simulation stopped on an error"
    exit 1
fi
echo "Simulation finished without failure"
